// ==== run.sh ====
#!/bin/sh
# build and run the cache testbench with Verilator
set -e

verilator --binary --assert --timescale 1ns/10ps \
    --top-module tb_cache -f vlog.f -o tb_cache_sim

./obj_dir/tb_cache_sim | tee sim.log

grep -qx '>>> PASS' sim.log

// ==== sim/tb_cache.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "cache_defs.svh"

module tb_cache;
    import cache_pkg::*;
    import mem_bus_pkg::*;

    localparam int N_DIRECTED  = 11;
    localparam int N_RANDOM    = 200;
    localparam int CYCLE_LIMIT = 40 * (N_DIRECTED + N_RANDOM) + 8;

    logic      clk;
    logic      resetn;
    logic      valid;
    logic      op;
    index_t    index;
    tag_t      tag;
    logic [3:0] offset;
    strb_t     wstrb;
    word_t     wdata;
    logic      addr_ok;
    logic      data_ok;
    word_t     rdata;
    logic      rd_req;
    mem_type_e rd_type;
    logic [31:0] rd_addr;
    logic      rd_rdy;
    logic      ret_valid;
    logic      ret_last;
    word_t     ret_data;
    logic      wr_req;
    mem_type_e wr_type;
    logic [31:0] wr_addr;
    strb_t     wr_wstrb;
    line_t     wr_data;
    logic      wr_rdy;

    // shadow holds every accepted store, backing only what was written back
    word_t shadow  [logic [29:0]];
    word_t backing [logic [29:0]];

    // outstanding requests in acceptance order
    logic        pend_read  [256];
    logic [29:0] pend_addr  [256];
    word_t       pend_word  [256];
    int          pend_cycle [256];
    int pend_head = 0;
    int pend_tail = 0;

    int cycle = 0;
    int errors = 0;
    int checks = 0;
    int rsp_errors = 0;
    int rsp_checks = 0;
    int mem_errors = 0;
    int mem_checks = 0;
    int last_rd_latency = 0;
    int last_wr_latency = 0;
    int rd_count = 0;
    int wr_count = 0;
    logic [31:0] last_rd_addr = '0;
    logic [31:0] last_wr_addr = '0;
    int test_num = 0;
    int test_err0 = 0;

    tb_clk_gen u_clk (
        .clk (clk)
    );

    cache_top u_dut (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .op        (op),
        .index     (index),
        .tag       (tag),
        .offset    (offset),
        .wstrb     (wstrb),
        .wdata     (wdata),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_type   (rd_type),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_type   (wr_type),
        .wr_addr   (wr_addr),
        .wr_wstrb  (wr_wstrb),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // initial memory contents spread over the whole word address
    function automatic word_t mem_hash(input logic [29:0] wa);
        logic [31:0] h;
        h = {2'b00, wa} * 32'h9e3779b1;
        return h ^ (h >> 15) ^ 32'h0badf00d;
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t data,
                                          input strb_t strb);
        word_t res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[i*8 +: 8] = data[i*8 +: 8];
            end
        end
        return res;
    endfunction

    // reference model of what a read must return
    function automatic word_t expected_word(input logic [29:0] wa);
        return shadow.exists(wa) ? shadow[wa] : mem_hash(wa);
    endfunction

    function automatic word_t stored_word(input logic [29:0] wa);
        return backing.exists(wa) ? backing[wa] : mem_hash(wa);
    endfunction

    function automatic int error_total();
        return errors + rsp_errors + mem_errors;
    endfunction

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        checks++;
        assert (got === exp) else begin
            $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        int now_err;
        now_err = error_total();
        test_num++;
        $display("test %0d, %s: %s", test_num, name, (now_err == test_err0) ? "ok" : "failed");
        test_err0 = now_err;
    endtask

    // starts on a falling edge, returns on the falling edge after acceptance
    task automatic issue_request(input logic is_wr, input tag_t t, input index_t idx,
                                 input bank_t bk, input strb_t strb, input word_t data,
                                 output int acc);
        logic [29:0] wa;
        int slot;
        valid  = 1'b1;
        op     = is_wr;
        tag    = t;
        index  = idx;
        offset = {bk, 2'b00};
        wstrb  = strb;
        wdata  = data;
        @(posedge clk);
        while (!addr_ok) @(posedge clk);
        acc  = cycle;
        wa   = {t, idx, bk};
        slot = pend_tail % 256;
        if (is_wr) begin
            shadow[wa] = merge_bytes(expected_word(wa), data, strb);
        end
        pend_read[slot]  = !is_wr;
        pend_addr[slot]  = wa;
        pend_word[slot]  = expected_word(wa);
        pend_cycle[slot] = cycle;
        pend_tail <= pend_tail + 1;
        @(negedge clk);
        valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (pend_head != pend_tail) @(negedge clk);
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    always @(posedge clk) begin : check_responses
        int slot;
        slot = pend_head % 256;
        if (resetn && data_ok) begin
            rsp_checks++;
            assert (pend_head != pend_tail) else begin
                $display("data_ok pulsed at %0t with no request outstanding", $time);
                rsp_errors++;
            end
            if (pend_head != pend_tail) begin
                if (pend_read[slot]) begin
                    last_rd_latency = cycle - pend_cycle[slot];
                    assert (rdata === pend_word[slot]) else begin
                        $display("[ERROR] %0t: read of word %0h returned %0h, expected %0h",
                                 $time, pend_addr[slot], rdata, pend_word[slot]);
                        rsp_errors++;
                    end
                end else begin
                    last_wr_latency = cycle - pend_cycle[slot];
                end
                pend_head = pend_head + 1;
            end
        end
    end

    // answers line reads and writebacks after 0 to 3 idle cycles
    initial begin : memory_model
        logic [31:0] mseed;
        logic [27:0] line_no;
        rd_rdy    = 1'b0;
        wr_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        mseed = lcg_next(32'd36);
        forever begin
            @(posedge clk);
            if (resetn && wr_req) begin
                mseed = lcg_next(mseed);
                repeat (mseed[25:24]) @(posedge clk);
                @(negedge clk);
                wr_rdy = 1'b1;
                @(posedge clk);
                wr_count++;
                last_wr_addr = wr_addr;
                line_no = wr_addr[31:4];
                mem_checks++;
                assert (wr_type == LINE && wr_wstrb == 4'hf && wr_addr[3:0] == 4'h0) else begin
                    $display("[ERROR] %0t: writeback has a wrong type, strobe or alignment",
                             $time);
                    mem_errors++;
                end
                for (int b = 0; b < `BANKS; b++) begin
                    mem_checks++;
                    assert (wr_data[b*`WORD_W +: `WORD_W] === expected_word({line_no, 2'(b)}))
                    else begin
                        $display("[ERROR] %0t: writeback of word %0h is %0h, expected %0h",
                                 $time, {line_no, 2'(b)}, wr_data[b*`WORD_W +: `WORD_W],
                                 expected_word({line_no, 2'(b)}));
                        mem_errors++;
                    end
                    backing[{line_no, 2'(b)}] = wr_data[b*`WORD_W +: `WORD_W];
                end
                @(negedge clk);
                wr_rdy = 1'b0;
            end else if (resetn && rd_req) begin
                mseed = lcg_next(mseed);
                repeat (mseed[25:24]) @(posedge clk);
                @(negedge clk);
                rd_rdy = 1'b1;
                @(posedge clk);
                rd_count++;
                last_rd_addr = rd_addr;
                line_no = rd_addr[31:4];
                mem_checks++;
                assert (rd_type == LINE && rd_addr[3:0] == 4'h0) else begin
                    $display("[ERROR] %0t: line read has a wrong type or alignment", $time);
                    mem_errors++;
                end
                // four beats back to back
                for (int b = 0; b < `BANKS; b++) begin
                    @(negedge clk);
                    rd_rdy    = 1'b0;
                    ret_valid = 1'b1;
                    ret_last  = (b == `BANKS - 1);
                    ret_data  = stored_word({line_no, 2'(b)});
                    @(posedge clk);
                end
                @(negedge clk);
                ret_valid = 1'b0;
                ret_last  = 1'b0;
            end
        end
    end

    initial begin : watchdog
        while (cycle < CYCLE_LIMIT) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display(">>> FAIL");
        $finish;
    end

    initial begin : run_tests
        int acc_w;
        int acc_r;
        int start;
        int rd0;
        int wr0;
        logic [31:0] seed;
        logic [31:0] data;
        resetn = 1'b0;
        valid  = 1'b0;
        op     = 1'b0;
        index  = '0;
        tag    = '0;
        offset = '0;
        wstrb  = '0;
        wdata  = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        repeat (3) begin
            @(posedge clk);
            check_equal({28'b0, data_ok, rd_req, wr_req, addr_ok}, 32'd0, "idle outputs");
        end
        @(negedge clk);
        start = cycle;
        issue_request(1'b0, 20'h00010, 8'h10, 2'd0, 4'h0, 32'h0, acc_r);
        check_equal(32'(acc_r - start), 32'd0, "cycles until addr_ok");
        wait_idle();
        end_test("reset state");

        rd0 = rd_count;
        issue_request(1'b0, 20'h00abc, 8'h21, 2'd1, 4'h0, 32'h0, acc_r);
        wait_idle();
        check_equal(32'(rd_count - rd0), 32'd1, "line reads on a miss");
        check_equal(last_rd_addr, {20'h00abc, 8'h21, 4'h0}, "line read address");
        rd0 = rd_count;
        issue_request(1'b0, 20'h00abc, 8'h21, 2'd3, 4'h0, 32'h0, acc_r);
        wait_idle();
        check_equal(32'(rd_count - rd0), 32'd0, "line reads on a hit");
        check_equal(32'(last_rd_latency), 32'd1, "read hit latency");
        end_test("read miss then hit");

        // read right behind the store stalls on the same bank
        issue_request(1'b1, 20'h00abc, 8'h21, 2'd2, 4'b0101, 32'hdeadbeef, acc_w);
        issue_request(1'b0, 20'h00abc, 8'h21, 2'd2, 4'h0, 32'h0, acc_r);
        wait_idle();
        check_equal(32'(last_wr_latency), 32'd2, "write hit latency");
        check_equal(32'(acc_r - acc_w), 32'd3, "acceptance gap after a store");
        check_equal(32'(last_rd_latency), 32'd1, "read hit latency");
        end_test("write hit partial strobes");

        rd0 = rd_count;
        issue_request(1'b1, 20'h00777, 8'h42, 2'd1, 4'b1100, 32'h12345678, acc_w);
        wait_idle();
        check_equal(32'(rd_count - rd0), 32'd1, "line reads on a write miss");
        issue_request(1'b0, 20'h00777, 8'h42, 2'd1, 4'h0, 32'h0, acc_r);
        issue_request(1'b0, 20'h00777, 8'h42, 2'd0, 4'h0, 32'h0, acc_r);
        wait_idle();
        check_equal(32'(rd_count - rd0), 32'd1, "line reads after the refill");
        end_test("write miss merge");

        wr0 = wr_count;
        issue_request(1'b0, 20'h00888, 8'h42, 2'd0, 4'h0, 32'h0, acc_r);
        wait_idle();
        check_equal(32'(wr_count - wr0), 32'd1, "writebacks of a dirty victim");
        check_equal(last_wr_addr, {20'h00777, 8'h42, 4'h0}, "writeback address");
        wr0 = wr_count;
        issue_request(1'b0, 20'h00999, 8'h42, 2'd3, 4'h0, 32'h0, acc_r);
        wait_idle();
        issue_request(1'b0, 20'h00777, 8'h42, 2'd1, 4'h0, 32'h0, acc_r);
        wait_idle();
        check_equal(32'(wr_count - wr0), 32'd0, "writebacks of clean victims");
        end_test("dirty eviction");

        // 4 indexes and 3 tags so lines keep evicting each other
        seed = 32'd36;
        for (int i = 0; i < N_RANDOM; i++) begin
            seed = lcg_next(seed);
            data = lcg_next(seed);
            issue_request(seed[31], 20'h01000 + 20'(seed[30:16] % 3),
                          8'h60 + {6'b0, seed[15:14]}, seed[13:12], seed[11:8], data, acc_w);
            seed = data;
        end
        wait_idle();
        end_test("random mix");

        $display("%0d tests, %0d checks, %0d errors", test_num,
                 checks + rsp_checks + mem_checks, error_total());
        if (error_total() == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/tb_clk_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
    parameter int HALF_PERIOD = 5
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== source/cache_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_ctrl (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   valid,
    input  logic                   op,
    input  cache_pkg::index_t      index,
    input  cache_pkg::tag_t        tag,
    input  logic [3:0]             offset,
    input  mem_bus_pkg::strb_t     wstrb,
    input  cache_pkg::word_t       wdata,
    output logic                   addr_ok,
    output logic                   data_ok,
    output cache_pkg::word_t       rdata,
    output logic                   rd_req,
    output mem_bus_pkg::mem_type_e rd_type,
    output logic [31:0]            rd_addr,
    input  logic                   rd_rdy,
    input  logic                   ret_last,
    output logic                   wr_req,
    output mem_bus_pkg::mem_type_e wr_type,
    output logic [31:0]            wr_addr,
    output mem_bus_pkg::strb_t     wr_wstrb,
    output cache_pkg::line_t       wr_data,
    input  logic                   wr_rdy,
    input  logic                   hit,
    input  cache_pkg::word_t       load_word,
    input  cache_pkg::tag_t        victim_tag,
    input  logic                   victim_dirty,
    input  cache_pkg::line_t       victim_line,
    input  logic                   store_en,
    input  logic                   conflict,
    input  cache_pkg::word_t       refill_word,
    output logic                   lookup_en,
    output cache_pkg::index_t      req_index,
    output cache_pkg::tag_t        req_tag,
    output cache_pkg::bank_t       req_bank,
    output logic                   req_is_write,
    output mem_bus_pkg::strb_t     req_wstrb,
    output cache_pkg::word_t       req_wdata,
    output logic                   capture
);
    import cache_pkg::*;
    import mem_bus_pkg::*;

    cache_state_e state;
    cache_state_e state_nx;
    cache_addr_u  rd_a;
    cache_addr_u  wr_a;

    assign addr_ok   = state == IDLE && valid && !conflict;
    assign lookup_en = addr_ok;
    assign capture   = state == LOOKUP && hit && req_is_write;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            state <= state_nx;
        end
    end

    always_comb begin
        state_nx = state;
        case (state)
            IDLE:    if (addr_ok) state_nx = LOOKUP;
            LOOKUP:  state_nx = hit ? IDLE : MISS;
            // clean victim needs no writeback
            MISS:    if (!victim_dirty || wr_rdy) state_nx = REPLACE;
            REPLACE: if (rd_rdy) state_nx = REFILL;
            REFILL:  if (ret_last) state_nx = IDLE;
            default: state_nx = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (lookup_en) begin
            req_is_write <= op;
            req_index    <= index;
            req_tag      <= tag;
            req_bank     <= offset[3:2];
            req_wstrb    <= wstrb;
            req_wdata    <= wdata;
        end
    end

    // read hit, delayed store, or end of refill
    assign data_ok = (state == LOOKUP && hit && !req_is_write)
                  || store_en
                  || (state == REFILL && ret_last);
    assign rdata   = (state == REFILL) ? refill_word : load_word;

    // line-aligned addresses
    always_comb begin
        rd_a.fld.tag      = req_tag;
        rd_a.fld.index    = req_index;
        rd_a.fld.bank     = '0;
        rd_a.fld.byte_off = '0;
        wr_a              = rd_a;
        wr_a.fld.tag      = victim_tag;
    end

    assign rd_req   = state == REPLACE;
    assign rd_type  = LINE;
    assign rd_addr  = rd_a.raw;
    assign wr_req   = state == MISS && victim_dirty;
    assign wr_type  = LINE;
    assign wr_addr  = wr_a.raw;
    assign wr_wstrb = 4'hf;
    assign wr_data  = victim_line;

    a_no_data_ok_mid_miss: assert property (@(posedge clk) disable iff (!resetn)
        (state == MISS || state == REPLACE) |-> !data_ok);

endmodule

`default_nettype wire

// ==== source/cache_defs.svh ====
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// direct-mapped, 256 sets of 16-byte lines
`define CACHE_SETS 256
`define INDEX_W    8
`define TAG_W      20

// a line is four word banks
`define BANKS      4
`define WORD_W     32
`define LINE_W     128

`endif

// ==== source/cache_pkg.sv ====
`default_nettype none
`include "cache_defs.svh"

package cache_pkg;

    typedef logic [`INDEX_W-1:0]         index_t;
    typedef logic [`TAG_W-1:0]           tag_t;
    typedef logic [$clog2(`BANKS)-1:0]   bank_t;
    typedef logic [`WORD_W-1:0]          word_t;
    // bank 0 sits in the low word
    typedef logic [`LINE_W-1:0]          line_t;

    // memory byte address, raw or split into cache fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            tag_t        tag;
            index_t      index;
            bank_t       bank;
            logic [1:0]  byte_off;
        } fld;
    } cache_addr_u;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REPLACE,
        REFILL
    } cache_state_e;

endpackage

`default_nettype wire

// ==== source/cache_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_top (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   valid,
    input  logic                   op,
    input  cache_pkg::index_t      index,
    input  cache_pkg::tag_t        tag,
    input  logic [3:0]             offset,
    input  mem_bus_pkg::strb_t     wstrb,
    input  cache_pkg::word_t       wdata,
    output logic                   addr_ok,
    output logic                   data_ok,
    output cache_pkg::word_t       rdata,
    output logic                   rd_req,
    output mem_bus_pkg::mem_type_e rd_type,
    output logic [31:0]            rd_addr,
    input  logic                   rd_rdy,
    input  logic                   ret_valid,
    input  logic                   ret_last,
    input  cache_pkg::word_t       ret_data,
    output logic                   wr_req,
    output mem_bus_pkg::mem_type_e wr_type,
    output logic [31:0]            wr_addr,
    output mem_bus_pkg::strb_t     wr_wstrb,
    output cache_pkg::line_t       wr_data,
    input  logic                   wr_rdy
);
    import cache_pkg::*;
    import mem_bus_pkg::*;

    logic   hit;
    word_t  load_word;
    tag_t   victim_tag;
    logic   victim_dirty;
    line_t  victim_line;
    logic   lookup_en;
    index_t req_index;
    tag_t   req_tag;
    bank_t  req_bank;
    logic   req_is_write;
    strb_t  req_wstrb;
    word_t  req_wdata;
    logic   capture;
    logic   store_en;
    index_t store_index;
    bank_t  store_bank;
    strb_t  store_wstrb;
    word_t  store_data;
    logic   conflict;
    logic   refill_en;
    bank_t  refill_bank;
    strb_t  refill_wstrb;
    word_t  refill_data;
    logic   refill_done;
    word_t  refill_word;

    cache_ctrl u_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .valid        (valid),
        .op           (op),
        .index        (index),
        .tag          (tag),
        .offset       (offset),
        .wstrb        (wstrb),
        .wdata        (wdata),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .rdata        (rdata),
        .rd_req       (rd_req),
        .rd_type      (rd_type),
        .rd_addr      (rd_addr),
        .rd_rdy       (rd_rdy),
        .ret_last     (ret_last),
        .wr_req       (wr_req),
        .wr_type      (wr_type),
        .wr_addr      (wr_addr),
        .wr_wstrb     (wr_wstrb),
        .wr_data      (wr_data),
        .wr_rdy       (wr_rdy),
        .hit          (hit),
        .load_word    (load_word),
        .victim_tag   (victim_tag),
        .victim_dirty (victim_dirty),
        .victim_line  (victim_line),
        .store_en     (store_en),
        .conflict     (conflict),
        .refill_word  (refill_word),
        .lookup_en    (lookup_en),
        .req_index    (req_index),
        .req_tag      (req_tag),
        .req_bank     (req_bank),
        .req_is_write (req_is_write),
        .req_wstrb    (req_wstrb),
        .req_wdata    (req_wdata),
        .capture      (capture)
    );

    cache_way u_way (
        .clk          (clk),
        .resetn       (resetn),
        .lookup_en    (lookup_en),
        .lookup_index (index),
        .req_index    (req_index),
        .req_tag      (req_tag),
        .req_bank     (req_bank),
        .store_en     (store_en),
        .store_index  (store_index),
        .store_bank   (store_bank),
        .store_wstrb  (store_wstrb),
        .store_data   (store_data),
        .refill_en    (refill_en),
        .refill_bank  (refill_bank),
        .refill_wstrb (refill_wstrb),
        .refill_data  (refill_data),
        .refill_done  (refill_done),
        .refill_dirty (req_is_write),
        .hit          (hit),
        .load_word    (load_word),
        .victim_tag   (victim_tag),
        .victim_dirty (victim_dirty),
        .victim_line  (victim_line)
    );

    store_buffer u_store (
        .clk          (clk),
        .resetn       (resetn),
        .capture      (capture),
        .req_index    (req_index),
        .req_bank     (req_bank),
        .req_wstrb    (req_wstrb),
        .req_wdata    (req_wdata),
        .new_index    (index),
        .new_bank     (offset[3:2]),
        .store_en     (store_en),
        .store_index  (store_index),
        .store_bank   (store_bank),
        .store_wstrb  (store_wstrb),
        .store_data   (store_data),
        .conflict     (conflict)
    );

    refill_buffer u_refill (
        .clk          (clk),
        .resetn       (resetn),
        .ret_valid    (ret_valid),
        .ret_last     (ret_last),
        .ret_data     (ret_data),
        .req_bank     (req_bank),
        .req_is_write (req_is_write),
        .req_wstrb    (req_wstrb),
        .req_wdata    (req_wdata),
        .refill_en    (refill_en),
        .refill_bank  (refill_bank),
        .refill_wstrb (refill_wstrb),
        .refill_data  (refill_data),
        .refill_done  (refill_done),
        .refill_word  (refill_word)
    );

endmodule

`default_nettype wire

// ==== source/cache_way.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "cache_defs.svh"

module cache_way (
    input  logic                clk,
    input  logic                resetn,
    input  logic                lookup_en,
    input  cache_pkg::index_t   lookup_index,
    input  cache_pkg::index_t   req_index,
    input  cache_pkg::tag_t     req_tag,
    input  cache_pkg::bank_t    req_bank,
    input  logic                store_en,
    input  cache_pkg::index_t   store_index,
    input  cache_pkg::bank_t    store_bank,
    input  mem_bus_pkg::strb_t  store_wstrb,
    input  cache_pkg::word_t    store_data,
    input  logic                refill_en,
    input  cache_pkg::bank_t    refill_bank,
    input  mem_bus_pkg::strb_t  refill_wstrb,
    input  cache_pkg::word_t    refill_data,
    input  logic                refill_done,
    input  logic                refill_dirty,
    output logic                hit,
    output cache_pkg::word_t    load_word,
    output cache_pkg::tag_t     victim_tag,
    output logic                victim_dirty,
    output cache_pkg::line_t    victim_line
);
    import cache_pkg::*;
    import mem_bus_pkg::*;

    logic [`TAG_W:0]       tagv_rdata;
    logic [`CACHE_SETS-1:0] valid_bits;
    logic [`CACHE_SETS-1:0] dirty_bits;
    word_t                 bank_rdata [`BANKS];
    index_t                wr_index;
    strb_t                 wr_strb;
    word_t                 wr_word;

    sram_1r1w #(.WIDTH(`TAG_W + 1)) u_tagv (
        .clk   (clk),
        .re    (lookup_en),
        .raddr (lookup_index),
        .rdata (tagv_rdata),
        .we    (refill_done),
        .wstrb (4'hf),
        .waddr (req_index),
        .wdata ({req_tag, 1'b1})
    );

    // refill owns the write port while it runs
    assign wr_index = refill_en ? req_index : store_index;
    assign wr_strb  = refill_en ? refill_wstrb : store_wstrb;
    assign wr_word  = refill_en ? refill_data : store_data;

    for (genvar b = 0; b < `BANKS; b++) begin : g_bank
        logic bank_we;

        assign bank_we = (store_en && store_bank == bank_t'(b))
                      || (refill_en && refill_bank == bank_t'(b));

        sram_1r1w #(.WIDTH(`WORD_W)) u_data (
            .clk   (clk),
            .re    (lookup_en),
            .raddr (lookup_index),
            .rdata (bank_rdata[b]),
            .we    (bank_we),
            .wstrb (wr_strb),
            .waddr (wr_index),
            .wdata (wr_word)
        );

        assign victim_line[b*`WORD_W +: `WORD_W] = bank_rdata[b];
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            if (refill_done) begin
                valid_bits[req_index] <= 1'b1;
            end
            if (store_en) begin
                dirty_bits[store_index] <= 1'b1;
            end else if (refill_done) begin
                dirty_bits[req_index] <= refill_dirty;
            end
        end
    end

    assign hit          = valid_bits[req_index] && tagv_rdata[0]
                       && tagv_rdata[`TAG_W:1] == req_tag;
    assign load_word    = bank_rdata[req_bank];
    assign victim_tag   = tagv_rdata[`TAG_W:1];
    assign victim_dirty = dirty_bits[req_index];

    // store buffer and refill never share the write port
    a_one_writer: assert property (@(posedge clk) disable iff (!resetn)
        !(store_en && refill_en));

endmodule

`default_nettype wire

// ==== source/mem_bus_pkg.sv ====
`default_nettype none

package mem_bus_pkg;

    typedef enum logic [2:0] {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010,
        LINE = 3'b100
    } mem_type_e;

    typedef logic [3:0] strb_t;

endpackage

`default_nettype wire

// ==== source/refill_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module refill_buffer (
    input  logic                clk,
    input  logic                resetn,
    input  logic                ret_valid,
    input  logic                ret_last,
    input  cache_pkg::word_t    ret_data,
    input  cache_pkg::bank_t    req_bank,
    input  logic                req_is_write,
    input  mem_bus_pkg::strb_t  req_wstrb,
    input  cache_pkg::word_t    req_wdata,
    output logic                refill_en,
    output cache_pkg::bank_t    refill_bank,
    output mem_bus_pkg::strb_t  refill_wstrb,
    output cache_pkg::word_t    refill_data,
    output logic                refill_done,
    output cache_pkg::word_t    refill_word
);
    import cache_pkg::*;

    bank_t beat;
    word_t merged;
    word_t word_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            beat <= '0;
        end else if (ret_valid) begin
            beat <= ret_last ? '0 : beat + 1'b1;
        end
    end

    // store bytes replace the returned ones in the requested bank
    always_comb begin
        merged = ret_data;
        if (req_is_write && beat == req_bank) begin
            for (int i = 0; i < 4; i++) begin
                if (req_wstrb[i]) begin
                    merged[i*8 +: 8] = req_wdata[i*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ret_valid && beat == req_bank) begin
            word_q <= merged;
        end
    end

    assign refill_en    = ret_valid;
    assign refill_bank  = beat;
    assign refill_wstrb = 4'hf;
    assign refill_data  = merged;
    assign refill_done  = ret_valid && ret_last;
    // requested bank may arrive with the last beat
    assign refill_word  = (refill_done && beat == req_bank) ? merged : word_q;

    a_last_on_fourth: assert property (@(posedge clk) disable iff (!resetn)
        (ret_valid && ret_last) |-> beat == '1);

endmodule

`default_nettype wire

// ==== source/sram_1r1w.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "cache_defs.svh"

module sram_1r1w #(
    parameter int WIDTH = 32,
    parameter int DEPTH = `CACHE_SETS
) (
    input  logic                clk,
    input  logic                re,
    input  cache_pkg::index_t   raddr,
    output logic [WIDTH-1:0]    rdata,
    input  logic                we,
    input  mem_bus_pkg::strb_t  wstrb,
    input  cache_pkg::index_t   waddr,
    input  logic [WIDTH-1:0]    wdata
);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [WIDTH-1:0] wmask;
    logic [WIDTH-1:0] wmerged;

    // byte lanes only on word-wide RAMs
    always_comb begin
        for (int i = 0; i < WIDTH; i++) begin
            wmask[i] = (WIDTH == 32) ? wstrb[i/8] : 1'b1;
        end
    end

    assign wmerged = (mem[waddr] & ~wmask) | (wdata & wmask);

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wmerged;
        end
        // same-row write forwarded to the read port
        if (re) begin
            rdata <= (we && waddr == raddr) ? wmerged : mem[raddr];
        end
    end

endmodule

`default_nettype wire

// ==== source/store_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module store_buffer (
    input  logic                clk,
    input  logic                resetn,
    input  logic                capture,
    input  cache_pkg::index_t   req_index,
    input  cache_pkg::bank_t    req_bank,
    input  mem_bus_pkg::strb_t  req_wstrb,
    input  cache_pkg::word_t    req_wdata,
    input  cache_pkg::index_t   new_index,
    input  cache_pkg::bank_t    new_bank,
    output logic                store_en,
    output cache_pkg::index_t   store_index,
    output cache_pkg::bank_t    store_bank,
    output mem_bus_pkg::strb_t  store_wstrb,
    output cache_pkg::word_t    store_data,
    output logic                conflict
);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            store_en <= 1'b0;
        end else begin
            store_en <= capture;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            store_index <= req_index;
            store_bank  <= req_bank;
            store_wstrb <= req_wstrb;
            store_data  <= req_wdata;
        end
    end

    // new request would read the word still being written
    assign conflict = store_en && store_index == new_index && store_bank == new_bank;

    a_no_back_to_back: assert property (@(posedge clk) disable iff (!resetn)
        capture |-> !store_en);

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+source
source/cache_pkg.sv
source/mem_bus_pkg.sv
source/sram_1r1w.sv
source/cache_way.sv
source/store_buffer.sv
source/refill_buffer.sv
source/cache_ctrl.sv
source/cache_top.sv
sim/tb_clk_gen.sv
sim/tb_cache.sv
